/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN        = 32;
    localparam int REG_AW      = 5;
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_AW     = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);
    localparam int MUL_CYCLES  = 3;
    localparam int MUL_CW      = $clog2(MUL_CYCLES);
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam word_t ECALL_WORD = 32'h0000_0073;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // Opcode sits in the same bits in both views
    typedef union packed {
        instr_r_t r_fmt;
        instr_i_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MUL} alu_op_t;

endpackage

/* design/rv_instr_if.sv */
`timescale 1ns/100ps

interface rv_instr_if
    import rv_pkg::*;
();

    logic   valid;
    word_t  pc;
    instr_u instr;
    logic   take;   // Receiver accepts this cycle

    modport src (
        output valid,
        output pc,
        output instr,
        input  take
    );

    modport dst (
        input  valid,
        input  pc,
        input  instr,
        output take
    );

endinterface

/* design/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               load_en_i,
    input  logic [IMEM_AW-1:0] load_addr_i,
    input  word_t              load_data_i,
    input  logic               run_i,
    rv_instr_if.src            out
);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t cur_word;
    logic  stopped;
    logic  xfer;

    // Program memory load port
    always_ff @(posedge clk) begin
        if (load_en_i) begin
            imem[load_addr_i] <= load_data_i;
        end
    end

    assign cur_word = imem[pc[IMEM_AW+1:2]];   // Word addressed

    assign out.valid = run_i && !stopped;
    assign out.pc    = pc;
    assign out.instr = cur_word;

    assign xfer = out.valid && out.take;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc      <= RESET_PC;
            stopped <= 1'b0;
        end else if (xfer) begin
            pc <= pc + word_t'(4);
            // Nothing past the ECALL leaves fetch
            if (cur_word == ECALL_WORD) begin
                stopped <= 1'b1;
            end
        end
    end

endmodule

/* design/rv_fetch_queue.sv */
`timescale 1ns/100ps

module rv_fetch_queue
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    rv_instr_if.dst in,
    rv_instr_if.src out
);

    word_t  pc_mem    [QUEUE_DEPTH];
    instr_u instr_mem [QUEUE_DEPTH];

    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;
    logic                push;
    logic                pop;

    assign in.take   = count != (QUEUE_AW+1)'(QUEUE_DEPTH);
    assign out.valid = count != '0;
    assign out.pc    = pc_mem[rd_ptr];
    assign out.instr = instr_mem[rd_ptr];

    assign push = in.valid && in.take;
    assign pop  = out.valid && out.take;

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]    <= in.pc;
            instr_mem[wr_ptr] <= in.instr;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    rv_instr_if.dst  in,
    output logic     retire_valid_o,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output word_t    retire_data_o,
    output logic     done_o
);

    word_t rf [2**REG_AW];

    logic [6:0] dec_opcode;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    reg_idx_t   dec_rd;
    word_t      dec_imm;
    logic       dec_is_imm;
    logic       dec_ecall;
    alu_op_t    dec_op;
    word_t      op_a;
    word_t      op_b;

    logic              ex_valid;
    word_t             ex_pc;
    reg_idx_t          ex_rd;
    alu_op_t           ex_op;
    word_t             ex_a;
    word_t             ex_b;
    logic              ex_ecall;
    logic [MUL_CW-1:0] mul_cnt;
    logic              ex_fire;
    logic              fwd_valid;
    logic              take_now;
    word_t             alu_res;

    assign dec_opcode = in.instr.r_fmt.opcode;
    assign dec_is_imm = dec_opcode == OP_IMM;
    assign dec_ecall  = dec_opcode == OP_SYSTEM;

    always_comb begin
        dec_rs1 = in.instr.r_fmt.rs1;
        dec_rs2 = in.instr.r_fmt.rs2;
        dec_rd  = '0;
        dec_imm = '0;
        dec_op  = ALU_ADD;
        if (dec_is_imm) begin
            // ADDI is the only I-type op
            dec_rd  = in.instr.i_fmt.rd;
            dec_imm = {{(XLEN-12){in.instr.i_fmt.imm12[11]}}, in.instr.i_fmt.imm12};
        end else if (dec_opcode == OP_REG) begin
            dec_rd = in.instr.r_fmt.rd;
            if (in.instr.r_fmt.funct7 == F7_MULDIV && in.instr.r_fmt.funct3 == F3_MUL) begin
                dec_op = ALU_MUL;
            end else begin
                case (in.instr.r_fmt.funct3)
                    F3_ADD_SUB: dec_op = (in.instr.r_fmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    default:    dec_op = ALU_ADD;
                endcase
            end
        end
    end

    // Result leaving execute this cycle bypasses the register file
    assign fwd_valid = ex_fire && ex_rd != '0;

    always_comb begin
        op_a = rf[dec_rs1];
        if (dec_rs1 == '0) begin
            op_a = '0;
        end else if (fwd_valid && dec_rs1 == ex_rd) begin
            op_a = alu_res;
        end
    end

    always_comb begin
        op_b = rf[dec_rs2];
        if (dec_is_imm) begin
            op_b = dec_imm;
        end else if (dec_rs2 == '0) begin
            op_b = '0;
        end else if (fwd_valid && dec_rs2 == ex_rd) begin
            op_b = alu_res;
        end
    end

    always_comb begin
        case (ex_op)
            ALU_SUB: alu_res = ex_a - ex_b;
            ALU_AND: alu_res = ex_a & ex_b;
            ALU_OR:  alu_res = ex_a | ex_b;
            ALU_XOR: alu_res = ex_a ^ ex_b;
            ALU_MUL: alu_res = ex_a * ex_b;   // Low half only
            default: alu_res = ex_a + ex_b;
        endcase
    end

    assign ex_fire = ex_valid && (ex_op != ALU_MUL || mul_cnt == MUL_CW'(MUL_CYCLES - 1));

    // Hold off while a multiply is running or an ECALL is pending
    assign in.take  = !(done_o || (ex_valid && !ex_fire) || (ex_valid && ex_ecall));
    assign take_now = in.valid && in.take;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid       <= 1'b0;
            mul_cnt        <= '0;
            retire_valid_o <= 1'b0;
            done_o         <= 1'b0;
        end else begin
            retire_valid_o <= ex_fire;
            if (ex_fire && ex_ecall) begin
                done_o <= 1'b1;
            end
            if (take_now) begin
                ex_valid <= 1'b1;
            end else if (ex_fire) begin
                ex_valid <= 1'b0;
            end
            mul_cnt <= (ex_valid && !ex_fire) ? mul_cnt + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_now) begin
            ex_pc    <= in.pc;
            ex_rd    <= dec_rd;
            ex_op    <= dec_op;
            ex_a     <= op_a;
            ex_b     <= op_b;
            ex_ecall <= dec_ecall;
        end
        if (ex_fire) begin
            retire_pc_o   <= ex_pc;
            retire_rd_o   <= ex_rd;
            retire_data_o <= ex_ecall ? '0 : alu_res;
            if (ex_rd != '0) begin
                rf[ex_rd] <= alu_res;   // x0 stays zero
            end
        end
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/100ps

module rv_core
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               load_en_i,
    input  logic [IMEM_AW-1:0] load_addr_i,
    input  word_t              load_data_i,
    input  logic               run_i,
    output logic               retire_valid_o,
    output word_t              retire_pc_o,
    output reg_idx_t           retire_rd_o,
    output word_t              retire_data_o,
    output logic               done_o
);

    rv_instr_if f2q ();   // Fetch to queue
    rv_instr_if q2x ();   // Queue to execute

    rv_fetch rv_fetch_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .run_i       (run_i),
        .out         (f2q.src)
    );

    rv_fetch_queue rv_fetch_queue_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in      (f2q.dst),
        .out     (q2x.src)
    );

    rv_execute rv_execute_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in             (q2x.dst),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .done_o         (done_o)
    );

endmodule

/* dv/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam int          CLK_HALF  = 10;
    localparam int          RESET_CYC = 10;
    localparam int          DRAIN_CYC = QUEUE_DEPTH + MUL_CYCLES + 4;
    localparam logic [31:0] RAND_SEED = 32'h3d87;

    typedef logic [8*4-1:0] token_t;

    logic               clk;
    logic               rst_n_i;
    logic               load_en_i;
    logic [IMEM_AW-1:0] load_addr_i;
    word_t              load_data_i;
    logic               run_i;
    logic               retire_valid_o;
    word_t              retire_pc_o;
    reg_idx_t           retire_rd_o;
    word_t              retire_data_o;
    logic               done_o;

    // Current test, filled from the golden file
    logic [IMEM_AW-1:0] ld_addr [IMEM_DEPTH];
    word_t              ld_word [IMEM_DEPTH];
    word_t              exp_pc   [$];
    reg_idx_t           exp_rd   [$];
    word_t              exp_data [$];
    int                 n_loads;

    int cycle_cnt   = 0;
    int cycle_limit = RESET_CYC + 100;

    rv_core rv_core_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .load_en_i      (load_en_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .run_i          (run_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .done_o         (done_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping on first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_run($sformatf("timeout: test still running at cycle %0d", cycle_cnt));
        end
    end

    task automatic check_retire(input word_t pc, input reg_idx_t rd, input word_t data);
        if (retire_pc_o !== pc) begin
            stop_run($sformatf("mismatch at %0t: retire_pc_o got %h expected %h",
                               $time, retire_pc_o, pc));
        end
        if (retire_rd_o !== rd) begin
            stop_run($sformatf("mismatch at %0t: retire_rd_o got %0d expected %0d",
                               $time, retire_rd_o, rd));
        end
        if (retire_data_o !== data) begin
            stop_run($sformatf("mismatch at %0t: retire_data_o got %h expected %h",
                               $time, retire_data_o, data));
        end
    endtask

    task automatic check_done(input logic exp);
        if (done_o !== exp) begin
            stop_run($sformatf("mismatch at %0t: done_o got %b expected %b", $time, done_o, exp));
        end
    endtask

    task automatic run_test(input logic pause);
        int idx;
        idx = 0;
        cycle_limit = cycle_cnt + RESET_CYC + n_loads + MUL_CYCLES * exp_pc.size() + 100;
        @(negedge clk);
        rst_n_i = 1'b0;
        run_i   = 1'b0;
        for (int i = 0; i < n_loads; i++) begin   // Program loads during reset
            load_en_i   = 1'b1;
            load_addr_i = ld_addr[i];
            load_data_i = ld_word[i];
            @(negedge clk);
        end
        load_en_i = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        rst_n_i = 1'b1;
        check_done(1'b0);
        run_i = 1'b1;
        while (!done_o) begin
            @(negedge clk);
            if (pause) begin
                run_i = ($urandom % 4) != 0;   // Drop run_i about one cycle in four
            end
            if (retire_valid_o) begin
                if (idx >= exp_pc.size()) begin
                    stop_run($sformatf("unexpected retirement at pc %h", retire_pc_o));
                end else begin
                    check_retire(exp_pc[idx], exp_rd[idx], exp_data[idx]);
                    idx++;
                end
            end
        end
        if (idx != exp_pc.size()) begin
            stop_run($sformatf("done after only %0d of %0d retirements", idx, exp_pc.size()));
        end
        // Nothing may retire past the ECALL
        repeat (DRAIN_CYC) begin
            @(negedge clk);
            if (pause) begin
                run_i = ($urandom % 4) != 0;
            end
            if (retire_valid_o) begin
                stop_run($sformatf("retirement at pc %h after ECALL", retire_pc_o));
            end
            check_done(1'b1);
        end
        run_i = 1'b0;
    endtask

    initial begin
        int          fd;
        int          n_tests;
        int          pause_val;
        int          addr_val;
        int          rd_val;
        word_t       word_val;
        word_t       data_val;
        token_t      kw;
        logic [8*128-1:0] line;
        rst_n_i     = 1'b0;
        load_en_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        run_i       = 1'b0;
        n_loads     = 0;
        n_tests     = 0;
        pause_val   = 0;
        void'($urandom(RAND_SEED));
        fd = $fopen("dv/golden_rv.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open dv/golden_rv.txt");
        end else begin
            while ($fscanf(fd, "%s", kw) == 1) begin
                if (kw == token_t'("#")) begin
                    void'($fgets(line, fd));   // Rest of a comment line
                end else if (kw == token_t'("T")) begin
                    if ($fscanf(fd, "%d", pause_val) != 1) begin
                        stop_run("bad test header in golden file");
                    end
                    n_loads = 0;
                    exp_pc.delete();
                    exp_rd.delete();
                    exp_data.delete();
                end else if (kw == token_t'("L")) begin
                    if ($fscanf(fd, "%h %h", addr_val, word_val) != 2) begin
                        stop_run("bad load line in golden file");
                    end
                    ld_addr[n_loads] = IMEM_AW'(addr_val);
                    ld_word[n_loads] = word_val;
                    n_loads++;
                end else if (kw == token_t'("E")) begin
                    if ($fscanf(fd, "%h %d %h", word_val, rd_val, data_val) != 3) begin
                        stop_run("bad expect line in golden file");
                    end
                    exp_pc.push_back(word_val);
                    exp_rd.push_back(reg_idx_t'(rd_val));
                    exp_data.push_back(data_val);
                end else if (kw == token_t'("end")) begin
                    n_tests++;
                    run_test(pause_val != 0);
                end else begin
                    stop_run($sformatf("unknown token %0s in golden file", kw));
                end
            end
            $fclose(fd);
            if (n_tests == 0) begin
                stop_run("no tests found in golden file");
            end else begin
                $display("Simulation PASSED");
                $finish;
            end
        end
    end

endmodule

/* dv/golden_rv.txt */
# L <word addr hex> <instr hex> loads program memory, E <pc hex> <rd dec> <data hex> is a retirement
# T <pause 0|1> opens a test and end runs it, pause 1 drops run_i at random
# ALU ops on ADDI values
T 0
L 0 12300093
L 1 0F000113
L 2 002081B3
L 3 40208233
L 4 0020F2B3
L 5 0020E333
L 6 0020C3B3
L 7 00000073
E 00 1 00000123
E 04 2 000000F0
E 08 3 00000213
E 0C 4 00000033
E 10 5 00000020
E 14 6 000001F3
E 18 7 000001D3
E 1C 0 00000000
end
# Negative immediates and x0
T 0
L 0 FFF00093
L 1 80008113
L 2 7FF00193
L 3 00508013
L 4 00000233
L 5 003002B3
L 6 00000073
E 00 1 FFFFFFFF
E 04 2 FFFFF7FF
E 08 3 000007FF
E 0C 0 00000004
E 10 4 00000000
E 14 5 000007FF
E 18 0 00000000
end
# Dependent chain
T 0
L 0 00700093
L 1 00908093
L 2 00108133
L 3 401101B3
L 4 0021C1B3
L 5 FCF18293
L 6 00000073
E 00 1 00000007
E 04 1 00000010
E 08 2 00000020
E 0C 3 00000010
E 10 3 00000030
E 14 5 FFFFFFFF
E 18 0 00000000
end
# Back-to-back MUL with dependent ADD
T 0
L 0 7FF00093
L 1 FFD00113
L 2 022081B3
L 3 02318233
L 4 021202B3
L 5 00328333
L 6 00000073
E 00 1 000007FF
E 04 2 FFFFFFFD
E 08 3 FFFFE803
E 0C 4 023F7009
E 10 5 F940D7F7
E 14 6 F940BFFA
E 18 0 00000000
end
# Words after ECALL with run_i pauses
T 1
L 0 05500093
L 1 02108133
L 2 001141B3
L 3 00000073
L 4 00100213
L 5 001082B3
E 00 1 00000055
E 04 2 00001C39
E 08 3 00001C6C
E 0C 0 00000000
end

/* tb.f */
design/rv_pkg.sv
design/rv_instr_if.sv
design/rv_fetch.sv
design/rv_fetch_queue.sv
design/rv_execute.sv
design/rv_core.sv
dv/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f tb.f -o sim_tb_rv_core \
    && ./obj_dir/sim_tb_rv_core | tee sim.log \
    || exit 1
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
